/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_eeprom_wr \
		-f sim.f -Mdir obj_dir -o sim_eeprom

run: compile
	./obj_dir/sim_eeprom | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/bus_cond_gen.sv */
`timescale 1ns/1ns
module bus_cond_gen (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 scl,
    input  logic                 low_mid,
    input  logic                 high_mid,
    input  logic                 cond_go,
    input  eeprom_pkg::cond_op_t cond_op,
    output logic                 cond_done,
    output logic                 sda
);

    typedef enum logic [1:0] {
        C_IDLE,
        C_LOW,      // waiting for low_mid
        C_HIGH      // waiting for high_mid
    } cond_state_t;

    cond_state_t          state;
    eeprom_pkg::cond_op_t op_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= C_IDLE;
            cond_done <= 1'b0;
            sda       <= 1'b1;  // released bus level
        end
        else
        begin
            cond_done <= 1'b0;
            case (state)
                C_IDLE:
                    if (cond_go)
                    begin
                        if (low_mid && !scl)
                        begin
                            // go lined up with the low phase, act now
                            sda   <= (cond_op == eeprom_pkg::COND_START);
                            state <= C_HIGH;
                        end
                        else
                        begin
                            state <= C_LOW;
                        end
                    end
                C_LOW:
                    if (low_mid && !scl)
                    begin
                        sda   <= (op_q == eeprom_pkg::COND_START);  // high for start, low for stop
                        state <= C_HIGH;
                    end
                C_HIGH:
                    if (high_mid && scl)
                    begin
                        sda       <= ~sda;  // the edge itself, SCL high
                        cond_done <= 1'b1;
                        state     <= C_IDLE;
                    end
                default:
                    state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cond_go && state == C_IDLE)
        begin
            op_q <= cond_op;
        end
    end

endmodule

/* design/byte_shifter.sv */
`timescale 1ns/1ns
module byte_shifter (
    input  logic   CLK,
    input  logic   RESET,
    input  logic   low_mid,
    input  logic   high_mid,
    input  logic   sda_in,
    output logic   sda,
    shift_if.unit  shift
);

    localparam int DW = eeprom_pkg::DATA_W;
    localparam int BW = $clog2(DW);
    localparam logic [BW-1:0] LAST_BIT = BW'(DW - 1);

    logic [DW-1:0] sr;          // tx bits still to send, or rx bits so far
    logic [BW-1:0] bit_cnt;
    logic          active;
    logic          rx_mode;

    // bit counting and the SDA bit
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active     <= 1'b0;
            bit_cnt    <= '0;
            shift.done <= 1'b0;
            sda        <= 1'b1;
        end
        else
        begin
            shift.done <= 1'b0;
            if (shift.go && !active)
            begin
                active  <= 1'b1;
                bit_cnt <= '0;
                if (!shift.read)
                begin
                    sda <= shift.tx_byte[DW-1];    // MSB out right away, go comes at low_mid
                end
            end
            else if (active && high_mid)
            begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT)
                begin
                    active     <= 1'b0;
                    shift.done <= 1'b1;
                end
            end
            else if (active && low_mid && !rx_mode)
            begin
                sda <= sr[DW-1];
            end
        end
    end

    // shift register
    always_ff @(posedge CLK)
    begin
        if (shift.go && !active)
        begin
            sr      <= {shift.tx_byte[DW-2:0], 1'b0};
            rx_mode <= shift.read;
        end
        else if (active && high_mid && rx_mode)
        begin
            sr <= {sr[DW-2:0], sda_in};     // sample mid high
        end
        else if (active && low_mid && !rx_mode)
        begin
            sr <= {sr[DW-2:0], 1'b0};
        end
    end

    assign shift.rx_byte = sr;

endmodule

/* design/eeprom_ctrl.sv */
`timescale 1ns/1ns
module eeprom_ctrl (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          low_mid,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wr_data,
    output logic [eeprom_pkg::DATA_W-1:0] rd_data,
    output logic                          ack,
    output logic                          busy,
    output logic                          cond_go,
    output eeprom_pkg::cond_op_t          cond_op,
    input  logic                          cond_done,
    input  logic                          cond_sda,
    shift_if.ctrl                         shift,
    input  logic                          shift_sda,
    output logic                          sda_out,
    output logic                          sda_oe
);

    localparam int AW = eeprom_pkg::ADDR_W;
    localparam int DW = eeprom_pkg::DATA_W;

    eeprom_pkg::ctrl_state_t state;
    logic [AW-1:0] addr_q;
    logic [DW-1:0] data_q;
    logic          rd_op;
    logic          unit_done;   // unit finished, hand over at next low_mid
    logic          accept;
    logic          step;

    assign accept = (state == eeprom_pkg::IDLE) && (wr || rd);
    assign step   = unit_done && low_mid;   // all ownership changes with SCL low
    assign ack    = (state == eeprom_pkg::DONE);
    assign busy   = (state != eeprom_pkg::IDLE);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::IDLE;
            unit_done <= 1'b0;
        end
        else
        begin
            if (step)
                unit_done <= 1'b0;
            else if ((cond_done || shift.done) && state != eeprom_pkg::STOP)
                unit_done <= 1'b1;

            case (state)
                eeprom_pkg::IDLE:    if (accept) state <= eeprom_pkg::START;
                eeprom_pkg::START:   if (step) state <= eeprom_pkg::CTRL_W;
                eeprom_pkg::CTRL_W:  if (step) state <= eeprom_pkg::ADDR;
                eeprom_pkg::ADDR:
                    if (step)
                        state <= rd_op ? eeprom_pkg::RESTART : eeprom_pkg::DATA_WR;
                eeprom_pkg::DATA_WR: if (step) state <= eeprom_pkg::STOP;
                eeprom_pkg::RESTART: if (step) state <= eeprom_pkg::CTRL_R;
                eeprom_pkg::CTRL_R:  if (step) state <= eeprom_pkg::DATA_R;
                eeprom_pkg::DATA_R:  if (step) state <= eeprom_pkg::STOP;
                eeprom_pkg::STOP:    if (cond_done) state <= eeprom_pkg::DONE;
                default:             state <= eeprom_pkg::IDLE;  // DONE included
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            addr_q <= addr;
            data_q <= wr_data;
            rd_op  <= !wr;  // wr wins over rd
        end
        if (state == eeprom_pkg::DATA_R && shift.done)
        begin
            rd_data <= shift.rx_byte;
        end
    end

    // next unit is started in the same cycle as the state change
    always_comb
    begin
        cond_go       = accept;
        cond_op       = eeprom_pkg::COND_START;
        shift.go      = 1'b0;
        shift.read    = 1'b0;
        shift.tx_byte = data_q;
        case (state)
            eeprom_pkg::START:
            begin
                shift.go      = step;
                shift.tx_byte = {eeprom_pkg::DEV_TAG, addr_q[AW-1:DW], 1'b0};
            end
            eeprom_pkg::CTRL_W:
            begin
                shift.go      = step;
                shift.tx_byte = addr_q[DW-1:0];
            end
            eeprom_pkg::ADDR:
            begin
                cond_go  = step && rd_op;   // repeated start
                shift.go = step && !rd_op;  // data byte
            end
            eeprom_pkg::RESTART:
            begin
                shift.go      = step;
                shift.tx_byte = {eeprom_pkg::DEV_TAG, addr_q[AW-1:DW], 1'b1};
            end
            eeprom_pkg::CTRL_R:
            begin
                shift.go   = step;
                shift.read = 1'b1;
            end
            eeprom_pkg::DATA_WR, eeprom_pkg::DATA_R:
            begin
                cond_go = step;
                cond_op = eeprom_pkg::COND_STOP;
            end
            default:
            begin
            end
        endcase
    end

    // SDA owner by state
    always_comb
    begin
        case (state)
            eeprom_pkg::START, eeprom_pkg::RESTART, eeprom_pkg::STOP:
            begin
                sda_out = cond_sda;
                sda_oe  = 1'b1;
            end
            eeprom_pkg::CTRL_W, eeprom_pkg::ADDR, eeprom_pkg::DATA_WR, eeprom_pkg::CTRL_R:
            begin
                sda_out = shift_sda;
                sda_oe  = 1'b1;
            end
            default:
            begin
                sda_out = 1'b1;     // released, slave or pull-up owns the bus
                sda_oe  = 1'b0;
            end
        endcase
    end

endmodule

/* design/eeprom_pkg.sv */
package eeprom_pkg;

    // address and data widths of the 2 Kbyte part
    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    localparam logic [3:0] DEV_TAG = 4'b1010;   // top nibble of every control byte

    // transaction sequencer states
    // DATA_WR is the data write byte, named apart from the DATA_W width
    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_WR,
        RESTART,
        CTRL_R,
        DATA_R,
        STOP,
        DONE
    } ctrl_state_t;

    // conditions the bus condition generator can place on SDA
    typedef enum logic {
        COND_START,
        COND_STOP
    } cond_op_t;

endpackage

/* design/eeprom_wr.sv */
`timescale 1ns/1ns
module eeprom_wr #(
    parameter int CLK_DIV = 4
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [eeprom_pkg::DATA_W-1:0] wr_data,
    output logic [eeprom_pkg::DATA_W-1:0] rd_data,
    output logic                          ack,
    output logic                          busy,
    output logic                          scl,
    output logic                          sda_out,
    output logic                          sda_oe,
    input  logic                          sda_in
);

    logic                 low_mid;
    logic                 high_mid;
    logic                 cond_go;
    eeprom_pkg::cond_op_t cond_op;
    logic                 cond_done;
    logic                 cond_sda;
    logic                 shift_sda;

    shift_if shift_bus ();

    scl_gen #(
        .CLK_DIV (CLK_DIV)
    ) scl_gen_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .scl      (scl),
        .low_mid  (low_mid),
        .high_mid (high_mid)
    );

    bus_cond_gen bus_cond_gen_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .low_mid   (low_mid),
        .high_mid  (high_mid),
        .cond_go   (cond_go),
        .cond_op   (cond_op),
        .cond_done (cond_done),
        .sda       (cond_sda)
    );

    byte_shifter byte_shifter_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .low_mid  (low_mid),
        .high_mid (high_mid),
        .sda_in   (sda_in),
        .sda      (shift_sda),
        .shift    (shift_bus.unit)
    );

    eeprom_ctrl eeprom_ctrl_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .low_mid   (low_mid),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .ack       (ack),
        .busy      (busy),
        .cond_go   (cond_go),
        .cond_op   (cond_op),
        .cond_done (cond_done),
        .cond_sda  (cond_sda),
        .shift     (shift_bus.ctrl),
        .shift_sda (shift_sda),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe)
    );

endmodule

/* design/scl_gen.sv */
`timescale 1ns/1ns
module scl_gen #(
    parameter int CLK_DIV = 4   // CLK cycles per SCL half, even and >= 4
) (
    input  logic CLK,
    input  logic RESET,
    output logic scl,
    output logic low_mid,
    output logic high_mid
);

    localparam int CW = $clog2(CLK_DIV);
    localparam logic [CW-1:0] RELOAD = CW'(CLK_DIV - 1);
    localparam logic [CW-1:0] MID = CW'(CLK_DIV / 2 - 1);  // CLK_DIV/2 cycles into a half

    logic [CW-1:0] cnt;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cnt <= RELOAD;
            scl <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt <= RELOAD;
            scl <= ~scl;    // end of half period
        end
        else
        begin
            cnt <= cnt - 1'b1;
        end
    end

    // strobes for SDA changes and sampling
    assign low_mid  = !scl && (cnt == MID);
    assign high_mid = scl && (cnt == MID);

endmodule

/* design/shift_if.sv */
`timescale 1ns/1ns
interface shift_if;

    logic                            go;        // one cycle, shifter idle
    logic                            read;      // 1 = shift in from sda_in
    logic [eeprom_pkg::DATA_W-1:0]   tx_byte;
    logic [eeprom_pkg::DATA_W-1:0]   rx_byte;   // valid from done to next go
    logic                            done;

    modport ctrl (
        output go,
        output read,
        output tx_byte,
        input  rx_byte,
        input  done
    );

    modport unit (
        input  go,
        input  read,
        input  tx_byte,
        output rx_byte,
        output done
    );

endinterface

/* sim.f */
design/eeprom_pkg.sv
design/shift_if.sv
design/scl_gen.sv
design/bus_cond_gen.sv
design/byte_shifter.sv
design/eeprom_ctrl.sv
design/eeprom_wr.sv
test/eeprom_model.sv
test/eeprom_wr_sva.sv
test/tb_eeprom_wr.sv

/* test/eeprom_model.sv */
`timescale 1ns/1ns
module eeprom_model (
    input  logic CLK,
    input  logic scl,
    input  logic sda,
    output logic sda_drv
);

    localparam int AW = eeprom_pkg::ADDR_W;
    localparam int DW = eeprom_pkg::DATA_W;

    logic [DW-1:0] mem [0:(1 << AW)-1];
    logic          scl_q = 1'b0;
    logic          sda_q = 1'b1;
    logic          drv_q = 1'b1;
    logic [DW-1:0] sr;
    logic [DW-1:0] tx;
    logic [AW-1:0] ptr;
    int            bit_cnt;
    int            byte_idx;    // bytes since the last start
    int            tx_cnt;
    logic          rd_mode;
    logic          selected;

    function automatic logic [DW-1:0] preset_byte(input logic [AW-1:0] a);
        return a[DW-1:0] ^ 8'h5A;
    endfunction

    assign sda_drv = drv_q;

    initial
    begin
        for (int a = 0; a < (1 << AW); a++)
        begin
            mem[a] = preset_byte(a[AW-1:0]);
        end
        bit_cnt  = 0;
        byte_idx = 0;
        tx_cnt   = 0;
        rd_mode  = 1'b0;
        selected = 1'b0;
    end

    // edges found from the previous CLK sample
    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl && scl_q && sda_q && !sda)
        begin
            bit_cnt  = 0;   // start or repeated start
            byte_idx = 0;
            rd_mode  = 1'b0;
            selected = 1'b1;
            drv_q   <= 1'b1;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            byte_idx = 0;   // stop
            rd_mode  = 1'b0;
            selected = 1'b0;
            drv_q   <= 1'b1;
        end
        else if (scl && !scl_q && selected && !rd_mode)
        begin
            sr = {sr[DW-2:0], sda};
            bit_cnt++;
            if (bit_cnt == DW)
            begin
                bit_cnt = 0;
                case (byte_idx)
                    0:
                    begin
                        selected      = (sr[DW-1:DW-4] == eeprom_pkg::DEV_TAG);
                        ptr[AW-1:DW]  = sr[3:1];
                        if (sr[0])
                        begin
                            rd_mode = 1'b1;
                            tx      = mem[ptr];
                            tx_cnt  = 0;
                        end
                    end
                    1:
                        ptr[DW-1:0] = sr;
                    2:
                        mem[ptr] = sr;
                    default:
                    begin
                    end
                endcase
                byte_idx++;
            end
        end
        else if (!scl && scl_q && rd_mode)
        begin
            if (tx_cnt < DW)
            begin
                drv_q <= tx[DW-1-tx_cnt];   // next bit while SCL low
                tx_cnt++;
            end
            else
            begin
                drv_q <= 1'b1;
            end
        end
    end

endmodule

/* test/eeprom_wr_sva.sv */
`timescale 1ns/1ns
module eeprom_wr_sva (
    input logic                    CLK,
    input logic                    RESET,
    input logic                    ack,
    input logic                    busy,
    input logic                    scl,
    input logic                    sda_out,
    input logic                    sda_oe,
    input eeprom_pkg::ctrl_state_t state
);

    logic in_cond;  // states where SDA may move with SCL high

    assign in_cond = (state == eeprom_pkg::START) || (state == eeprom_pkg::RESTART)
                     || (state == eeprom_pkg::STOP);

    ack_single: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack && !busy)
        else $error("ack longer than one cycle or busy still high after it");

    sda_steady: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !in_cond && !$past(in_cond)) |-> $stable(sda_out))
        else $error("sda_out moved while scl was high outside a bus condition");

    read_released: assert property (@(posedge CLK) disable iff (RESET)
        (state == eeprom_pkg::DATA_R) |-> !sda_oe)
        else $error("sda_oe high while the slave owns the data byte");

    reset_quiet: assert property (@(posedge CLK)
        (RESET && $past(RESET)) |-> (!ack && !busy && !sda_oe))
        else $error("outputs active during reset");

endmodule

bind eeprom_wr eeprom_wr_sva eeprom_wr_sva_inst (
    .CLK     (CLK),
    .RESET   (RESET),
    .ack     (ack),
    .busy    (busy),
    .scl     (scl),
    .sda_out (sda_out),
    .sda_oe  (sda_oe),
    .state   (eeprom_ctrl_inst.state)
);

/* test/tb_eeprom_wr.sv */
`timescale 1ns/1ns
module tb_eeprom_wr;

    parameter int CLK_DIV = 4;

    localparam int AW      = eeprom_pkg::ADDR_W;
    localparam int DW      = eeprom_pkg::DATA_W;
    localparam int TIMEOUT = 2000;
    localparam int QUIET   = 100 * CLK_DIV;    // longer than any transaction

    logic          CLK = 1'b0;
    logic          RESET;
    logic          wr;
    logic          rd;
    logic [AW-1:0] addr;
    logic [DW-1:0] wr_data;
    logic [DW-1:0] rd_data;
    logic          ack;
    logic          busy;
    logic          scl;
    logic          sda_out;
    logic          sda_oe;
    logic          slave_sda;
    logic          sda_bus;

    logic [DW-1:0] ref_mem [0:(1 << AW)-1];
    logic [DW-1:0] exp_q[$];        // expected bytes in read order
    logic [AW-1:0] addr_log[$];
    logic [15:0]   lfsr = 16'd88;
    int            errors = 0;
    int            compare_errors = 0;
    int            checked = 0;
    int            ack_count = 0;
    int            tests_run = 0;
    int            tests_failed = 0;

    always #2 CLK = ~CLK;

    // open-drain bus where a released side reads 1
    assign sda_bus = (sda_oe ? sda_out : 1'b1) & slave_sda;

    eeprom_wr #(
        .CLK_DIV (CLK_DIV)
    ) eeprom_wr_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .busy    (busy),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .sda_in  (sda_bus)
    );

    eeprom_model slave_inst (
        .CLK     (CLK),
        .scl     (scl),
        .sda     (sda_bus),
        .sda_drv (slave_sda)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            r    = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    // content of a location that was never written
    function automatic logic [DW-1:0] initial_byte(input logic [AW-1:0] a);
        return a[DW-1:0] ^ 8'h5A;
    endfunction

    function automatic logic [DW-1:0] expected_byte(input logic [AW-1:0] a);
        return ref_mem[a];
    endfunction

    function automatic int total_errors();
        return errors + compare_errors;
    endfunction

    always @(posedge CLK)
    begin
        if (!RESET && ack)
        begin
            ack_count <= ack_count + 1;
        end
    end

    // compare process checks each read ack
    always @(negedge CLK)
    begin
        if (!RESET && ack && checked < exp_q.size())
        begin
            if (rd_data !== exp_q[checked])
            begin
                $display("FAIL rd_data at addr %03h: got %02h expected %02h",
                         addr_log[checked], rd_data, exp_q[checked]);
                compare_errors++;
            end
            checked++;
        end
    end

    task automatic end_run();
        $display("tests run %0d, tests failed %0d, reads checked %0d, errors %0d",
                 tests_run, tests_failed, checked, total_errors());
        if (total_errors() == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ack(input string what);
        int n;
        n = 0;
        do
        begin
            @(negedge CLK);
            n++;
        end
        while (!ack && n < TIMEOUT);
        if (!ack)
        begin
            $display("timeout: no ack within %0d cycles during %s", TIMEOUT, what);
            errors++;
            end_run();
        end
    endtask

    task automatic do_write(input logic [AW-1:0] a, input logic [DW-1:0] d);
        @(negedge CLK);
        wr      = 1'b1;
        addr    = a;
        wr_data = d;
        ref_mem[a] = d;
        @(negedge CLK);
        wr = 1'b0;
        wait_ack("write");
        repeat (2) @(negedge CLK);
    endtask

    task automatic do_read(input logic [AW-1:0] a);
        @(negedge CLK);
        rd   = 1'b1;
        addr = a;
        exp_q.push_back(expected_byte(a));
        addr_log.push_back(a);
        @(negedge CLK);
        rd = 1'b0;
        wait_ack("read");
        repeat (2) @(negedge CLK);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (total_errors() == err_before)
        begin
            $display("test %0d %s: ok", tests_run, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, total_errors() - err_before);
        end
    endtask

    initial
    begin
        int          err0;
        int          acks0;
        logic [15:0] r_op;
        logic [15:0] r_addr;
        logic [15:0] r_data;

        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        for (int a = 0; a < (1 << AW); a++)
        begin
            ref_mem[a] = initial_byte(a[AW-1:0]);
        end
        repeat (16) @(negedge CLK);
        RESET = 1'b0;

        err0 = total_errors();
        @(negedge CLK);
        check_value("ack", 32'(ack), 32'h0);
        check_value("busy", 32'(busy), 32'h0);
        check_value("sda_oe", 32'(sda_oe), 32'h0);
        do_read(11'h0A3);
        report_test("after reset", err0);

        err0 = total_errors();
        do_write(11'h155, 8'h3C);
        do_read(11'h155);
        report_test("write then read", err0);

        // both ends of the range first since high bits ride in the control byte
        err0 = total_errors();
        do_write(11'h000, 8'hC3);
        do_read(11'h000);
        do_write(11'h7FF, 8'h96);
        do_read(11'h7FF);
        for (int i = 0; i < 40; i++)
        begin
            r_op   = rand_bits(1);
            r_addr = rand_bits(AW);
            r_data = rand_bits(DW);
            if (r_op[0])
            begin
                do_write(r_addr[AW-1:0], r_data[DW-1:0]);
            end
            do_read(r_addr[AW-1:0]);
        end
        report_test("random sequence", err0);

        err0  = total_errors();
        acks0 = ack_count;
        @(negedge CLK);
        wr      = 1'b1;
        rd      = 1'b1;
        addr    = 11'h2F0;
        wr_data = 8'hA5;
        ref_mem[11'h2F0] = 8'hA5;   // wr takes priority
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        wait_ack("same-cycle strobe");
        repeat (QUIET) @(negedge CLK);
        check_value("ack_count", 32'(ack_count), 32'(acks0 + 1));
        do_read(11'h2F0);
        report_test("same-cycle strobes", err0);

        err0  = total_errors();
        acks0 = ack_count;
        @(negedge CLK);
        wr      = 1'b1;
        addr    = 11'h3A5;
        wr_data = 8'h11;
        ref_mem[11'h3A5] = 8'h11;
        @(negedge CLK);
        wr = 1'b0;
        repeat (5) @(negedge CLK);
        check_value("busy", 32'(busy), 32'h1);
        wr      = 1'b1;     // should be dropped
        wr_data = 8'hEE;
        @(negedge CLK);
        wr = 1'b0;
        wait_ack("write while busy");
        repeat (QUIET) @(negedge CLK);
        check_value("ack_count", 32'(ack_count), 32'(acks0 + 1));
        check_value("busy", 32'(busy), 32'h0);
        do_read(11'h3A5);
        report_test("strobe while busy", err0);

        end_run();
    end

endmodule
